/* battery_monitor.f */
battery_monitor_pkg.sv
adc_scheduler.sv
bat_detect_fsm.sv
volt_averager.sv
bat_status.sv
backlight_pwm.sv
battery_monitor.sv
tb_clock.sv
battery_monitor_assert.sv
tb_battery_monitor.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_battery_monitor
FILELIST  ?= battery_monitor.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= STATUS: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_battery_monitor.sv */
// Runs with shortened timer parameters; the ADC model answers 1 to 5 cycles after each request
module tb_battery_monitor;

    localparam int TIMEOUT = 2000;

    logic clk;
    logic reset;
    logic reset_req = 1'b0;
    logic adc_ready = 1'b0;
    battery_monitor_pkg::volt_t adc_value = '0;
    logic charging, lcd_ready;
    logic second_tick = 1'b0;
    logic half_second_tick = 1'b0;
    logic [battery_monitor_pkg::BRIGHT_W-1:0] brightness;
    logic adc_req, adc_sel, type_valid, bat_lithium, volt_valid;
    logic low_battery, led_red, led_white, lcd_pwm, lowpower_backlight;
    battery_monitor_pkg::volt_t volt;

    battery_monitor_pkg::volt_t li_value;
    battery_monitor_pkg::volt_t aa_value;
    int adc_delay = 0;
    int tick_cnt;
    int errors = 0;
    int timeouts = 0;

    tb_clock i_tb_clock (.reset_req(reset_req), .clk(clk), .reset(reset));

    battery_monitor #(
        .ADC_INTERVAL(40), .SEL_LEAD(10), .SETTLE_SAMPLES(4), .VOTE_LIMIT(3), .AVG_SHIFT(2)
    ) i_battery_monitor (
        .clk(clk), .reset(reset), .adc_ready(adc_ready), .adc_value(adc_value),
        .charging(charging), .second_tick(second_tick), .half_second_tick(half_second_tick),
        .lcd_ready(lcd_ready), .brightness(brightness), .adc_req(adc_req), .adc_sel(adc_sel),
        .type_valid(type_valid), .bat_lithium(bat_lithium), .volt(volt),
        .volt_valid(volt_valid), .low_battery(low_battery), .led_red(led_red),
        .led_white(led_white), .lcd_pwm(lcd_pwm), .lowpower_backlight(lowpower_backlight)
    );

    always @(posedge clk) begin
        adc_ready <= 1'b0;
        if (adc_req) begin
            adc_delay <= $urandom_range(5, 1);
        end else if (adc_delay == 1) begin
            adc_ready <= 1'b1;
            adc_value <= adc_sel ? li_value : aa_value;  // Mux input chosen by DUT
            adc_delay <= 0;
        end else if (adc_delay > 1) begin
            adc_delay <= adc_delay - 1;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            tick_cnt         <= 0;
            second_tick      <= 1'b0;
            half_second_tick <= 1'b0;
        end else begin
            tick_cnt         <= (tick_cnt == 99) ? 0 : tick_cnt + 1;
            half_second_tick <= (tick_cnt == 49) || (tick_cnt == 99);
            second_tick      <= (tick_cnt == 99);
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_volt_valid(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < TIMEOUT && !ok; i++) begin
            @(posedge clk);
            ok = volt_valid;
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout at %0t: no volt_valid pulse arrived", $time);
        end
    endtask

    task automatic detect_type(input bit lithium_high);
        bit ok;
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        li_value  <= lithium_high ? 14'd1300 : 14'd300;  // Low side below VALID_MIN
        aa_value  <= lithium_high ? 14'd300 : 14'd1300;
        wait_cycles(6);
        ok = 1'b0;
        for (int i = 0; i < TIMEOUT && !ok; i++) begin
            @(posedge clk);
            ok = type_valid;
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout at %0t: battery type was never detected", $time);
        end else if (bat_lithium != lithium_high) begin
            errors++;
            $display("** Error at %0t: bat_lithium is %0b, expected %0b",
                     $time, bat_lithium, lithium_high);
        end
    endtask

    task automatic apply_volt(input battery_monitor_pkg::volt_t v);
        bit ok;
        if (bat_lithium) begin
            li_value <= v;
        end else begin
            aa_value <= v;
        end
        wait_volt_valid(ok);                   // First block may mix old samples
        for (int n = 0; n < 2 && ok; n++) begin
            wait_volt_valid(ok);
            if (ok && volt != v) begin
                errors++;
                $display("** Error at %0t: volt is %0d, expected %0d", $time, volt, v);
            end
        end
        wait_cycles(250);                      // Let blink phase run
    endtask

    initial begin
        void'($urandom(32'h06f7_3639));
        charging   = 1'b0;
        lcd_ready  = 1'b1;
        brightness = 4'd8;
        li_value   = '0;
        aa_value   = '0;

        detect_type(1'b1);
        apply_volt(14'd1300);
        apply_volt(14'd1100);                  // Below RED_LI
        charging <= 1'b1;
        apply_volt(14'd1300);
        apply_volt(14'd500);
        charging <= 1'b0;

        detect_type(1'b0);
        brightness <= 4'($urandom_range(15, 1));  // Nonzero so dimming shows
        apply_volt(14'd1200);
        apply_volt(14'd900);                   // Enter low power
        apply_volt(14'd1100);
        lcd_ready <= 1'b0;
        apply_volt(14'd1000);
        lcd_ready  <= 1'b1;
        brightness <= 4'($urandom_range(15, 0));
        apply_volt(14'd1350);                  // Exit low power
        apply_volt(14'd1050);

        report_result();
    end

    task automatic report_result();
        int asserts;
        asserts = i_battery_monitor.i_battery_monitor_assert.fail_count;
        $display("errors=%0d assertion_failures=%0d timeouts=%0d", errors, asserts, timeouts);
        if (errors == 0 && asserts == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

endmodule

/* battery_monitor_assert.sv */
// Checks use sampled values only; ADC answer latency must stay well below SEL_LEAD
module battery_monitor_assert #(
    parameter int ADC_INTERVAL = 41946,
    parameter int SEL_LEAD     = 1000
) (
    input logic                       clk,
    input logic                       reset,
    input logic                       adc_req,
    input logic                       adc_sel,
    input logic                       type_valid,
    input logic                       bat_lithium,
    input battery_monitor_pkg::volt_t volt,
    input logic                       charging,
    input logic                       second_tick,
    input logic                       half_second_tick,
    input logic                       lcd_ready,
    input logic                       low_battery,
    input logic                       led_red,
    input logic                       led_white,
    input logic                       lcd_pwm,
    input logic                       lowpower_backlight
);

    int unsigned fail_count = 0;
    int          req_gap;
    logic        req_seen;
    logic        half_seen;
    battery_monitor_pkg::volt_t red_thr;

    assign red_thr = bat_lithium ? battery_monitor_pkg::RED_LI : battery_monitor_pkg::RED_AA;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_gap   <= 0;
            req_seen  <= 1'b0;
            half_seen <= 1'b0;
        end else begin
            req_gap <= adc_req ? 0 : req_gap + 1;  // Cycles since last request
            if (adc_req) begin
                req_seen <= 1'b1;
            end
            if (half_second_tick) begin
                half_seen <= 1'b1;
            end
        end
    end

    req_width: assert property (@(posedge clk) disable iff (reset) adc_req |=> !adc_req)
        else begin fail_count++; $error("adc_req wider than one cycle"); end
    req_spacing: assert property (@(posedge clk) disable iff (reset)
        adc_req && req_seen |-> req_gap == ADC_INTERVAL)
        else begin fail_count++; $error("adc_req spacing %0d", req_gap); end
    sel_lead: assert property (@(posedge clk) disable iff (reset)
        req_seen && !type_valid && !$past(type_valid) && $changed(adc_sel)
        |-> req_gap == ADC_INTERVAL - SEL_LEAD)
        else begin fail_count++; $error("adc_sel moved off its lead slot"); end
    sel_pinned: assert property (@(posedge clk) disable iff (reset)
        type_valid |=> type_valid && adc_sel == bat_lithium)
        else begin fail_count++; $error("adc_sel not pinned to battery type"); end

    no_battery: assert property (@(posedge clk) disable iff (reset)
        volt < battery_monitor_pkg::VALID_MIN |=> !low_battery && !led_red && !led_white)
        else begin fail_count++; $error("status outputs active without battery"); end
    low_flag: assert property (@(posedge clk) disable iff (reset)
        !charging && volt >= battery_monitor_pkg::VALID_MIN && volt < red_thr |=> low_battery)
        else begin fail_count++; $error("low_battery missing below red threshold"); end
    red_blink: assert property (@(posedge clk) disable iff (reset)
        low_battery && $past(low_battery) && led_red != $past(led_red) |-> $past(second_tick, 2))
        else begin fail_count++; $error("led_red toggled without second_tick"); end
    red_follow: assert property (@(posedge clk) disable iff (reset)
        second_tick ##1 low_battery ##1 low_battery |-> led_red != $past(led_red))
        else begin fail_count++; $error("led_red did not toggle after second_tick"); end
    white_led: assert property (@(posedge clk) disable iff (reset)
        charging && bat_lithium && volt >= battery_monitor_pkg::VALID_MIN
        && volt < battery_monitor_pkg::FULL_LI |=> led_white)
        else begin fail_count++; $error("led_white missing while charging"); end

    lp_enter: assert property (@(posedge clk) disable iff (reset)
        !bat_lithium && volt >= battery_monitor_pkg::VALID_MIN
        && volt < battery_monitor_pkg::LOWPOWER_ENTER |=> lowpower_backlight)
        else begin fail_count++; $error("low power not entered"); end
    lp_hold: assert property (@(posedge clk) disable iff (reset)
        volt >= battery_monitor_pkg::LOWPOWER_ENTER && volt <= battery_monitor_pkg::LOWPOWER_EXIT
        |=> $stable(lowpower_backlight))
        else begin fail_count++; $error("low power changed inside band"); end
    lp_exit: assert property (@(posedge clk) disable iff (reset)
        !bat_lithium && volt > battery_monitor_pkg::LOWPOWER_EXIT |=> !lowpower_backlight)
        else begin fail_count++; $error("low power not left"); end
    lp_dim: assert property (@(posedge clk) disable iff (reset)
        lowpower_backlight && $past(lowpower_backlight) |-> !(lcd_pwm && $past(lcd_pwm)))
        else begin fail_count++; $error("lcd_pwm high twice in low power"); end
    pwm_gate: assert property (@(posedge clk) disable iff (reset)
        !lcd_ready || !half_seen |-> !lcd_pwm)
        else begin fail_count++; $error("lcd_pwm high while gated"); end

endmodule

bind battery_monitor battery_monitor_assert #(
    .ADC_INTERVAL (ADC_INTERVAL),
    .SEL_LEAD     (SEL_LEAD)
) i_battery_monitor_assert (
    .clk                (clk),
    .reset              (reset),
    .adc_req            (adc_req),
    .adc_sel            (adc_sel),
    .type_valid         (type_valid),
    .bat_lithium        (bat_lithium),
    .volt               (volt),
    .charging           (charging),
    .second_tick        (second_tick),
    .half_second_tick   (half_second_tick),
    .lcd_ready          (lcd_ready),
    .low_battery        (low_battery),
    .led_red            (led_red),
    .led_white          (led_white),
    .lcd_pwm            (lcd_pwm),
    .lowpower_backlight (lowpower_backlight)
);

/* tb_clock.sv */
// Reset is held for 4 clock cycles at start and again on each reset_req pulse
module tb_clock (
    input  logic reset_req,
    output logic clk,
    output logic reset
);

    logic [2:0] rst_cnt = 3'd4;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                // Period 20
    end

    always @(posedge clk) begin
        if (reset_req) begin
            rst_cnt <= 3'd4;
        end else if (rst_cnt != 3'd0) begin
            rst_cnt <= rst_cnt - 3'd1;
        end
    end

    assign reset = (rst_cnt != 3'd0);

endmodule

/* battery_monitor.sv */
// Defaults match the real ADC clocking; ADC answers may arrive late but never twice per request
module battery_monitor #(
    parameter int ADC_INTERVAL   = 41946,
    parameter int SEL_LEAD       = 1000,
    parameter int SETTLE_SAMPLES = 512,
    parameter int VOTE_LIMIT     = 127,
    parameter int AVG_SHIFT      = 8
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     adc_ready,
    input  battery_monitor_pkg::volt_t               adc_value,
    input  logic                                     charging,
    input  logic                                     second_tick,
    input  logic                                     half_second_tick,
    input  logic                                     lcd_ready,
    input  logic [battery_monitor_pkg::BRIGHT_W-1:0] brightness,
    output logic                                     adc_req,
    output logic                                     adc_sel,
    output logic                                     type_valid,
    output logic                                     bat_lithium,
    output battery_monitor_pkg::volt_t               volt,
    output logic                                     volt_valid,
    output logic                                     low_battery,
    output logic                                     led_red,
    output logic                                     led_white,
    output logic                                     lcd_pwm,
    output logic                                     lowpower_backlight
);

    logic track_sample;

    adc_scheduler #(
        .ADC_INTERVAL (ADC_INTERVAL),
        .SEL_LEAD     (SEL_LEAD)
    ) i_adc_scheduler (
        .clk         (clk),
        .reset       (reset),
        .type_valid  (type_valid),
        .bat_lithium (bat_lithium),
        .adc_req     (adc_req),
        .adc_sel     (adc_sel)
    );

    bat_detect_fsm #(
        .SETTLE_SAMPLES (SETTLE_SAMPLES),
        .VOTE_LIMIT     (VOTE_LIMIT)
    ) i_bat_detect_fsm (
        .clk          (clk),
        .reset        (reset),
        .adc_ready    (adc_ready),
        .adc_value    (adc_value),
        .adc_sel      (adc_sel),
        .type_valid   (type_valid),
        .bat_lithium  (bat_lithium),
        .track_sample (track_sample)
    );

    volt_averager #(
        .AVG_SHIFT (AVG_SHIFT)
    ) i_volt_averager (
        .clk          (clk),
        .reset        (reset),
        .track_sample (track_sample),
        .adc_value    (adc_value),
        .volt         (volt),
        .volt_valid   (volt_valid)
    );

    bat_status i_bat_status (
        .clk         (clk),
        .reset       (reset),
        .volt        (volt),
        .bat_lithium (bat_lithium),
        .charging    (charging),
        .second_tick (second_tick),
        .low_battery (low_battery),
        .led_red     (led_red),
        .led_white   (led_white)
    );

    backlight_pwm i_backlight_pwm (
        .clk                (clk),
        .reset              (reset),
        .volt               (volt),
        .bat_lithium        (bat_lithium),
        .brightness         (brightness),
        .lcd_ready          (lcd_ready),
        .half_second_tick   (half_second_tick),
        .lcd_pwm            (lcd_pwm),
        .lowpower_backlight (lowpower_backlight)
    );

endmodule

/* backlight_pwm.sv */
// Low-power dimming only tracks AA cells and forces brightness to zero rather than restoring it
module backlight_pwm (
    input  logic                                     clk,
    input  logic                                     reset,
    input  battery_monitor_pkg::volt_t               volt,
    input  logic                                     bat_lithium,
    input  logic [battery_monitor_pkg::BRIGHT_W-1:0] brightness,
    input  logic                                     lcd_ready,
    input  logic                                     half_second_tick,
    output logic                                     lcd_pwm,
    output logic                                     lowpower_backlight
);

    localparam int PWM_W = battery_monitor_pkg::PWM_W;
    localparam logic [PWM_W-1:0] PWM_LAST = PWM_W'(battery_monitor_pkg::PWM_PERIOD_MAX);

    logic                                     enabled;
    logic [PWM_W-1:0]                         pwm_cnt;
    logic [battery_monitor_pkg::BRIGHT_W-1:0] eff_bright;
    logic [PWM_W-1:0]                         pwm_cmp;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enabled <= 1'b0;
        end else if (half_second_tick) begin
            enabled <= 1'b1;                   // Backlight held off until first tick
        end
    end

    // Hysteresis band between enter and exit thresholds
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lowpower_backlight <= 1'b0;
        end else if (!bat_lithium && volt >= battery_monitor_pkg::VALID_MIN) begin
            if (!lowpower_backlight && volt < battery_monitor_pkg::LOWPOWER_ENTER) begin
                lowpower_backlight <= 1'b1;
            end else if (lowpower_backlight && volt > battery_monitor_pkg::LOWPOWER_EXIT) begin
                lowpower_backlight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_cnt <= '0;
        end else if (pwm_cnt == PWM_LAST) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    assign eff_bright = lowpower_backlight ? '0 : brightness;
    assign pwm_cmp    = PWM_W'(eff_bright) << battery_monitor_pkg::PWM_STEP_SHIFT;
    assign lcd_pwm    = enabled && lcd_ready && (pwm_cnt <= pwm_cmp);  // Level 0 still pulses once

endmodule

/* bat_status.sv */
// White LED only reports lithium charging since AA cells have no full threshold here
module bat_status (
    input  logic                       clk,
    input  logic                       reset,
    input  battery_monitor_pkg::volt_t volt,
    input  logic                       bat_lithium,
    input  logic                       charging,
    input  logic                       second_tick,
    output logic                       low_battery,
    output logic                       led_red,
    output logic                       led_white
);

    battery_monitor_pkg::volt_t red_thr;
    logic                       blink;
    logic                       volt_ok;
    logic                       below_red;

    assign red_thr   = bat_lithium ? battery_monitor_pkg::RED_LI : battery_monitor_pkg::RED_AA;
    assign volt_ok   = (volt >= battery_monitor_pkg::VALID_MIN);
    assign below_red = (volt < red_thr);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            blink <= 1'b0;
        end else if (second_tick) begin
            blink <= ~blink;                   // 1 Hz phase for the red LED
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            low_battery <= 1'b0;
            led_red     <= 1'b0;
            led_white   <= 1'b0;
        end else begin
            low_battery <= 1'b0;
            led_red     <= 1'b0;
            led_white   <= 1'b0;
            if (volt_ok) begin
                if (charging) begin
                    led_white <= bat_lithium && (volt < battery_monitor_pkg::FULL_LI);
                end else begin
                    low_battery <= below_red;
                    led_red     <= below_red && blink;
                end
            end
        end
    end

endmodule

/* volt_averager.sv */
// Block average of 2^AVG_SHIFT samples; a sample landing on the dump cycle is dropped
module volt_averager #(
    parameter int AVG_SHIFT = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       track_sample,
    input  battery_monitor_pkg::volt_t adc_value,
    output battery_monitor_pkg::volt_t volt,
    output logic                       volt_valid
);

    localparam int SUM_W = battery_monitor_pkg::VOLT_W + AVG_SHIFT;

    logic [SUM_W-1:0]   volt_sum;
    logic [AVG_SHIFT:0] volt_cnt;          // MSB marks a full block

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            volt_sum   <= '0;
            volt_cnt   <= '0;
            volt       <= '0;
            volt_valid <= 1'b0;
        end else begin
            volt_valid <= 1'b0;
            if (volt_cnt[AVG_SHIFT]) begin
                volt       <= volt_sum[SUM_W-1:AVG_SHIFT];
                volt_valid <= 1'b1;
                volt_sum   <= '0;
                volt_cnt   <= '0;
            end else if (track_sample) begin
                volt_sum <= volt_sum + SUM_W'(adc_value);
                volt_cnt <= volt_cnt + 1'b1;
            end
        end
    end

endmodule

/* bat_detect_fsm.sv */
// Type decision is made once per reset and never revisited; the input that reads higher wins
module bat_detect_fsm #(
    parameter int SETTLE_SAMPLES = 512,
    parameter int VOTE_LIMIT     = 127
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       adc_ready,
    input  battery_monitor_pkg::volt_t adc_value,
    input  logic                       adc_sel,
    output logic                       type_valid,
    output logic                       bat_lithium,
    output logic                       track_sample
);

    localparam int SETTLE_W = $clog2(SETTLE_SAMPLES + 1);
    localparam int VOTE_W   = $clog2(VOTE_LIMIT + 2) + 1;
    localparam logic [SETTLE_W-1:0]      SETTLE_LAST = SETTLE_W'(SETTLE_SAMPLES - 1);
    localparam logic signed [VOTE_W-1:0] VOTE_HI     = VOTE_W'(VOTE_LIMIT);
    localparam logic signed [VOTE_W-1:0] VOTE_LO     = -VOTE_W'(VOTE_LIMIT);

    battery_monitor_pkg::detect_state_t state;
    logic [SETTLE_W-1:0]                settle_cnt;
    logic signed [VOTE_W-1:0]           vote;         // Negative means lithium

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= battery_monitor_pkg::DETECT_SETTLE;
            settle_cnt  <= '0;
            vote        <= '0;
            bat_lithium <= 1'b0;
        end else begin
            case (state)
                battery_monitor_pkg::DETECT_SETTLE: begin
                    if (adc_ready) begin
                        settle_cnt <= settle_cnt + 1'b1;
                        if (settle_cnt == SETTLE_LAST) begin
                            state <= battery_monitor_pkg::DETECT_VOTE;
                        end
                    end
                end
                battery_monitor_pkg::DETECT_VOTE: begin
                    if (vote > VOTE_HI || vote < VOTE_LO) begin
                        state       <= battery_monitor_pkg::DETECT_TRACK;
                        bat_lithium <= vote[VOTE_W-1];
                    end else if (adc_ready && adc_value >= battery_monitor_pkg::VALID_MIN) begin
                        if (adc_sel) begin
                            vote <= vote - 1'b1;      // Lithium input read valid
                        end else begin
                            vote <= vote + 1'b1;
                        end
                    end
                end
                battery_monitor_pkg::DETECT_TRACK: begin
                    state <= battery_monitor_pkg::DETECT_TRACK;
                end
                default: begin
                    state <= battery_monitor_pkg::DETECT_SETTLE;
                end
            endcase
        end
    end

    assign type_valid   = (state == battery_monitor_pkg::DETECT_TRACK);
    assign track_sample = adc_ready && (state == battery_monitor_pkg::DETECT_TRACK);

endmodule

/* adc_scheduler.sv */
// Needs SEL_LEAD below ADC_INTERVAL; the mux only alternates until the battery type is known
module adc_scheduler #(
    parameter int ADC_INTERVAL = 41946,
    parameter int SEL_LEAD     = 1000
) (
    input  logic clk,
    input  logic reset,
    input  logic type_valid,
    input  logic bat_lithium,
    output logic adc_req,
    output logic adc_sel
);

    localparam int CNT_W = $clog2(ADC_INTERVAL + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(ADC_INTERVAL);
    localparam logic [CNT_W-1:0] CNT_SEL  = CNT_W'(ADC_INTERVAL - SEL_LEAD);

    logic [CNT_W-1:0] timer;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timer   <= '0;
            adc_req <= 1'b0;
        end else if (timer == CNT_LAST) begin
            timer   <= '0;
            adc_req <= 1'b1;                   // One pulse per interval
        end else begin
            timer   <= timer + 1'b1;
            adc_req <= 1'b0;
        end
    end

    // Switch the external mux ahead of the request so the input can settle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            adc_sel <= 1'b0;
        end else if (type_valid) begin
            adc_sel <= bat_lithium;            // Pinned to detected cell
        end else if (timer == CNT_SEL) begin
            adc_sel <= ~adc_sel;
        end
    end

endmodule

/* battery_monitor_pkg.sv */
// Thresholds are raw 14-bit ADC codes for the on-board divider and only hold for that front end
package battery_monitor_pkg;

    localparam int VOLT_W   = 14;
    localparam int BRIGHT_W = 4;

    typedef logic [VOLT_W-1:0] volt_t;

    // Below this the reading is treated as no battery at all
    localparam volt_t VALID_MIN = 14'd700;     // ~1.8 V

    localparam volt_t FULL_LI = 14'd1423;      // 3.75 V
    localparam volt_t RED_LI  = 14'd1182;      // 3.1 V
    localparam volt_t RED_AA  = 14'd1071;      // 2.8 V

    // AA backlight dimming band
    localparam volt_t LOWPOWER_ENTER = 14'd979;   // 2.55 V
    localparam volt_t LOWPOWER_EXIT  = 14'd1293;  // 3.4 V

    // Backlight PWM, period is PWM_PERIOD_MAX + 1 cycles
    localparam int PWM_W          = 9;
    localparam int PWM_PERIOD_MAX = 448;
    localparam int PWM_STEP_SHIFT = 4;         // 16 counts per brightness step

    typedef enum logic [1:0] {
        DETECT_SETTLE = 2'd0,                  // Waiting for readings to stabilize
        DETECT_VOTE   = 2'd1,                  // Comparing AA and lithium inputs
        DETECT_TRACK  = 2'd2                   // Type known
    } detect_state_t;

endpackage
